// ==== design/bridge_addr_pkg.sv ====
package bridge_addr_pkg;

   // the host sees a 30-bit slice of the GP1 port
   localparam int gp1_addr_width_lp = 30;

   // accelerator physical addresses and rebased PS addresses share one width
   localparam int bp_addr_width_lp = 32;
   localparam int word_width_lp = 32;

   // DRAM is tracked in 8 MB regions, numbered by address bits 29 down to 23
   localparam int region_idx_width_lp = 7;
   localparam int region_msb_lp = 29;

   typedef logic [gp1_addr_width_lp-1:0] gp1_addr_t;
   typedef logic [bp_addr_width_lp-1:0] bp_addr_t;
   typedef logic [word_width_lp-1:0] word_t;
   typedef logic [region_idx_width_lp-1:0] region_idx_t;

   // GP1 window layout as seen by the bridge
   //   0x0000_0000 .. 0x1fff_ffff  cached DRAM, moved up to 0x8000_0000
   //   0x2000_0000 .. 0x3fff_ffff  local space, moved down to 0x0000_0000
   localparam bp_addr_t win_split_lp = 32'h2000_0000;

   // start of cached DRAM in the accelerator map
   localparam bp_addr_t dram_base_lp = 32'h8000_0000;

   // only 256 MB of PS memory is set aside for the accelerator
   localparam bp_addr_t dram_limit_lp = 32'h1000_0000;

endpackage

// ==== design/bridge_csr_pkg.sv ====
package bridge_csr_pkg;

   // the host CSR port has eight word slots
   localparam int csr_idx_width_lp = 3;

   typedef logic [csr_idx_width_lp-1:0] csr_idx_t;

   // one bit per 8 MB DRAM region
   localparam int num_regions_lp = 128;

   typedef logic [num_regions_lp-1:0] region_map_t;

   // slot 0 is the accelerator run bit, low means held in reset
   localparam csr_idx_t csr_run_lp = 3'd0;

   // slot 1 tells the accelerator that PS memory has been allocated
   localparam csr_idx_t csr_alloc_lp = 3'd1;

   // slot 2 holds the physical base of that allocation
   localparam csr_idx_t csr_base_lp = 3'd2;

   // slots 4 to 7 read back the profiler bitmap, lowest word first
   localparam csr_idx_t csr_prof0_lp = 3'd4;
   localparam csr_idx_t csr_prof1_lp = 3'd5;
   localparam csr_idx_t csr_prof2_lp = 3'd6;
   localparam csr_idx_t csr_prof3_lp = 3'd7;

endpackage

// ==== design/gp1_window_xlate.sv ====
module gp1_window_xlate
   import bridge_addr_pkg::*;
   (input  logic      clk_i
   , input  logic      reset_i

   , input  logic      host_v_i
   , input  logic      host_we_i
   , input  gp1_addr_t host_addr_i
   , input  word_t     host_wdata_i

   , output logic      s1_v_o
   , output logic      s1_dram_o
   , output logic      s1_we_o
   , output bp_addr_t  s1_addr_o
   , output word_t     s1_wdata_o
   );

   bp_addr_t host_ext;
   bp_addr_t xlate_addr;

   // the low window lands in cached DRAM and the high window in local space
   always_comb begin
      host_ext = bp_addr_t'(host_addr_i);
      if (host_ext < win_split_lp) begin
         xlate_addr = host_ext + dram_base_lp;
      end else begin
         xlate_addr = host_ext - win_split_lp;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         s1_v_o <= 1'b0;
      end else begin
         s1_v_o <= host_v_i;
      end
   end

   // the rest of stage one is qualified by s1_v_o
   always_ff @(posedge clk_i) begin
      if (host_v_i) begin
         s1_dram_o  <= (xlate_addr >= dram_base_lp);
         s1_we_o    <= host_we_i;
         s1_addr_o  <= xlate_addr;
         s1_wdata_o <= host_wdata_i;
      end
   end

   // classification is made on the translated address, so check it against
   // the window the host actually used one cycle earlier
   a_dram_from_low_window: assert property (
      @(posedge clk_i) disable iff (reset_i)
      (s1_v_o && s1_dram_o) |-> ($past(host_ext) < win_split_lp)
   );

endmodule

// ==== design/dram_rebase.sv ====
module dram_rebase
   import bridge_addr_pkg::*;
   (input  logic     clk_i
   , input  logic     reset_i

   , input  logic     s1_v_i
   , input  logic     s1_dram_i
   , input  logic     s1_we_i
   , input  bp_addr_t s1_addr_i
   , input  word_t    s1_wdata_i

   , input  bp_addr_t dram_base_i

   , output logic     local_v_o
   , output logic     local_we_o
   , output bp_addr_t local_addr_o
   , output word_t    local_wdata_o

   , output logic     dram_v_o
   , output logic     dram_we_o
   , output bp_addr_t dram_addr_o
   , output word_t    dram_wdata_o
   , output logic     dram_oob_o
   );

   bp_addr_t dram_off;
   logic     dram_hit;
   logic     local_hit;

   // XOR strips the DRAM base, which leaves the offset into the PS allocation
   always_comb begin
      dram_off  = s1_addr_i ^ dram_base_lp;
      dram_hit  = s1_v_i & s1_dram_i;
      local_hit = s1_v_i & ~s1_dram_i;
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         local_v_o  <= 1'b0;
         dram_v_o   <= 1'b0;
         dram_oob_o <= 1'b0;
      end else begin
         local_v_o  <= local_hit;
         dram_v_o   <= dram_hit;
         dram_oob_o <= dram_hit & (dram_off >= dram_limit_lp);
      end
   end

   // local accesses keep their stage one address
   always_ff @(posedge clk_i) begin
      if (local_hit) begin
         local_we_o    <= s1_we_i;
         local_addr_o  <= s1_addr_i;
         local_wdata_o <= s1_wdata_i;
      end
   end

   // base register is sampled in the same cycle the access is registered
   always_ff @(posedge clk_i) begin
      if (dram_hit) begin
         dram_we_o    <= s1_we_i;
         dram_addr_o  <= dram_off + dram_base_i;
         dram_wdata_o <= s1_wdata_i;
      end
   end

   // every stage one access leaves on exactly one of the two ports
   a_one_port_per_access: assert property (
      @(posedge clk_i) disable iff (reset_i)
      $onehot0({local_v_o, dram_v_o}) && ((local_v_o || dram_v_o) == $past(s1_v_i))
   );

endmodule

// ==== design/mem_region_profiler.sv ====
module mem_region_profiler
   import bridge_addr_pkg::*;
   import bridge_csr_pkg::*;
   (input  logic        clk_i
   , input  logic        core_reset_i

   , input  logic        s1_v_i
   , input  logic        s1_dram_i
   , input  bp_addr_t    s1_addr_i

   , output region_map_t region_map_o
   );

   region_idx_t region_idx;
   region_map_t hit_mask;

   // bits 29:23 survive the DRAM base offset, so they number the region
   always_comb begin
      region_idx = s1_addr_i[region_msb_lp -: region_idx_width_lp];
      hit_mask   = '0;
      if (s1_v_i && s1_dram_i) begin
         hit_mask[region_idx] = 1'b1;
      end
   end

   // sticky until the accelerator is put back into reset
   always_ff @(posedge clk_i) begin
      if (core_reset_i) begin
         region_map_o <= '0;
      end else begin
         region_map_o <= region_map_o | hit_mask;
      end
   end

   a_map_only_grows: assert property (
      @(posedge clk_i)
      !core_reset_i |=> ((region_map_o & $past(region_map_o)) == $past(region_map_o))
   );

endmodule

// ==== design/host_csr_block.sv ====
module host_csr_block
   import bridge_addr_pkg::*;
   import bridge_csr_pkg::*;
   (input  logic        clk_i
   , input  logic        reset_i

   , input  logic        csr_we_i
   , input  logic        csr_re_i
   , input  csr_idx_t    csr_idx_i
   , input  word_t       csr_wdata_i

   , input  region_map_t region_map_i

   , output word_t       csr_rdata_o
   , output logic        csr_rvalid_o
   , output bp_addr_t    dram_base_o
   , output logic        core_reset_o
   );

   logic     run_r;
   logic     alloc_r;
   bp_addr_t base_r;
   word_t    rdata_mux;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         run_r   <= 1'b0;
         alloc_r <= 1'b0;
         base_r  <= '0;
      end else if (csr_we_i) begin
         case (csr_idx_i)
            csr_run_lp:   run_r   <= csr_wdata_i[0];
            csr_alloc_lp: alloc_r <= csr_wdata_i[0];
            csr_base_lp:  base_r  <= csr_wdata_i;
            default:      ;
         endcase
      end
   end

   // the profiler words are read only
   always_comb begin
      case (csr_idx_i)
         csr_run_lp:   rdata_mux = word_t'(run_r);
         csr_alloc_lp: rdata_mux = word_t'(alloc_r);
         csr_base_lp:  rdata_mux = base_r;
         csr_prof0_lp: rdata_mux = region_map_i[0*word_width_lp +: word_width_lp];
         csr_prof1_lp: rdata_mux = region_map_i[1*word_width_lp +: word_width_lp];
         csr_prof2_lp: rdata_mux = region_map_i[2*word_width_lp +: word_width_lp];
         csr_prof3_lp: rdata_mux = region_map_i[3*word_width_lp +: word_width_lp];
         default:      rdata_mux = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         csr_rvalid_o <= 1'b0;
      end else begin
         csr_rvalid_o <= csr_re_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (csr_re_i) begin
         csr_rdata_o <= rdata_mux;
      end
   end

   assign dram_base_o = base_r;

   // accelerator stays in reset until the host sets the run bit
   assign core_reset_o = reset_i | ~run_r;

   // a write to the bitmap slots would be dropped without notice
   a_no_profiler_write: assert property (
      @(posedge clk_i) disable iff (reset_i)
      csr_we_i |-> (csr_idx_i < csr_prof0_lp)
   );

endmodule

// ==== design/zynq_bridge_top.sv ====
module zynq_bridge_top
   import bridge_addr_pkg::*;
   import bridge_csr_pkg::*;
   (input  logic      clk_i
   , input  logic      reset_i

   , input  logic      host_v_i
   , input  logic      host_we_i
   , input  gp1_addr_t host_addr_i
   , input  word_t     host_wdata_i

   , input  logic      csr_we_i
   , input  logic      csr_re_i
   , input  csr_idx_t  csr_idx_i
   , input  word_t     csr_wdata_i

   , output logic      core_reset_o

   , output logic      local_v_o
   , output logic      local_we_o
   , output bp_addr_t  local_addr_o
   , output word_t     local_wdata_o

   , output logic      dram_v_o
   , output logic      dram_we_o
   , output bp_addr_t  dram_addr_o
   , output word_t     dram_wdata_o
   , output logic      dram_oob_o

   , output word_t     csr_rdata_o
   , output logic      csr_rvalid_o
   );

   logic        s1_v;
   logic        s1_dram;
   logic        s1_we;
   bp_addr_t    s1_addr;
   word_t       s1_wdata;
   bp_addr_t    dram_base;
   region_map_t region_map;

   gp1_window_xlate xlate0
      (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.host_v_i(host_v_i)
      ,.host_we_i(host_we_i)
      ,.host_addr_i(host_addr_i)
      ,.host_wdata_i(host_wdata_i)
      ,.s1_v_o(s1_v)
      ,.s1_dram_o(s1_dram)
      ,.s1_we_o(s1_we)
      ,.s1_addr_o(s1_addr)
      ,.s1_wdata_o(s1_wdata)
      );

   dram_rebase rebase0
      (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.s1_v_i(s1_v)
      ,.s1_dram_i(s1_dram)
      ,.s1_we_i(s1_we)
      ,.s1_addr_i(s1_addr)
      ,.s1_wdata_i(s1_wdata)
      ,.dram_base_i(dram_base)
      ,.local_v_o(local_v_o)
      ,.local_we_o(local_we_o)
      ,.local_addr_o(local_addr_o)
      ,.local_wdata_o(local_wdata_o)
      ,.dram_v_o(dram_v_o)
      ,.dram_we_o(dram_we_o)
      ,.dram_addr_o(dram_addr_o)
      ,.dram_wdata_o(dram_wdata_o)
      ,.dram_oob_o(dram_oob_o)
      );

   // profiler watches stage one and is cleared together with the accelerator
   mem_region_profiler prof0
      (.clk_i(clk_i)
      ,.core_reset_i(core_reset_o)
      ,.s1_v_i(s1_v)
      ,.s1_dram_i(s1_dram)
      ,.s1_addr_i(s1_addr)
      ,.region_map_o(region_map)
      );

   host_csr_block csr0
      (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.csr_we_i(csr_we_i)
      ,.csr_re_i(csr_re_i)
      ,.csr_idx_i(csr_idx_i)
      ,.csr_wdata_i(csr_wdata_i)
      ,.region_map_i(region_map)
      ,.csr_rdata_o(csr_rdata_o)
      ,.csr_rvalid_o(csr_rvalid_o)
      ,.dram_base_o(dram_base)
      ,.core_reset_o(core_reset_o)
      );

endmodule

// ==== dv/zynq_bridge_tb.sv ====
module zynq_bridge_tb
   import bridge_addr_pkg::*;
   import bridge_csr_pkg::*;
   ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int wait_limit_lp = 64;

   logic        clk_i = 1'b0;
   logic        reset_i;
   logic        host_v_i;
   logic        host_we_i;
   gp1_addr_t   host_addr_i;
   word_t       host_wdata_i;
   logic        csr_we_i;
   logic        csr_re_i;
   csr_idx_t    csr_idx_i;
   word_t       csr_wdata_i;

   logic        core_reset_o;
   logic        local_v_o;
   logic        local_we_o;
   bp_addr_t    local_addr_o;
   word_t       local_wdata_o;
   logic        dram_v_o;
   logic        dram_we_o;
   bp_addr_t    dram_addr_o;
   word_t       dram_wdata_o;
   logic        dram_oob_o;
   word_t       csr_rdata_o;
   logic        csr_rvalid_o;

   // reference state built from the register map and the address rules
   logic        run_m;
   logic        alloc_m;
   bp_addr_t    base_m;
   region_map_t map_m;

   // host access as seen one and two cycles after it was driven
   logic        p1_v;
   logic        p1_we;
   bp_addr_t    p1_addr;
   word_t       p1_wdata;
   logic        p2_v;
   logic        p2_low;
   logic        p2_we;
   logic        p2_oob;
   bp_addr_t    p2_dram_addr;
   bp_addr_t    p2_local_addr;
   word_t       p2_wdata;
   logic        exp_rvalid;
   word_t       exp_rdata;
   int          issued_count;
   int          out_count;
   bp_addr_t    rand_base;

   zynq_bridge_top dut0
      (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.host_v_i(host_v_i)
      ,.host_we_i(host_we_i)
      ,.host_addr_i(host_addr_i)
      ,.host_wdata_i(host_wdata_i)
      ,.csr_we_i(csr_we_i)
      ,.csr_re_i(csr_re_i)
      ,.csr_idx_i(csr_idx_i)
      ,.csr_wdata_i(csr_wdata_i)
      ,.core_reset_o(core_reset_o)
      ,.local_v_o(local_v_o)
      ,.local_we_o(local_we_o)
      ,.local_addr_o(local_addr_o)
      ,.local_wdata_o(local_wdata_o)
      ,.dram_v_o(dram_v_o)
      ,.dram_we_o(dram_we_o)
      ,.dram_addr_o(dram_addr_o)
      ,.dram_wdata_o(dram_wdata_o)
      ,.dram_oob_o(dram_oob_o)
      ,.csr_rdata_o(csr_rdata_o)
      ,.csr_rvalid_o(csr_rvalid_o)
      );

   always #20 clk_i = ~clk_i;

   task automatic abort_run();
      $display("Something failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic report_mismatch(input string sig_name, input word_t exp_val,
                                  input word_t act_val);
      $display("** Error at %0t ns: %s expected 0x%08h, got 0x%08h",
               $time, sig_name, exp_val, act_val);
      abort_run();
   endtask

   task automatic report_timeout(input string what);
      $display("timeout at %0t ns: %s", $time, what);
      abort_run();
   endtask

   function automatic word_t expected_read(input csr_idx_t idx);
      word_t val;
      case (idx)
         csr_run_lp:   val = word_t'(run_m);
         csr_alloc_lp: val = word_t'(alloc_m);
         csr_base_lp:  val = base_m;
         csr_prof0_lp: val = map_m[31:0];
         csr_prof1_lp: val = map_m[63:32];
         csr_prof2_lp: val = map_m[95:64];
         csr_prof3_lp: val = map_m[127:96];
         default:      val = '0;
      endcase
      return val;
   endfunction

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         p1_v       <= 1'b0;
         p2_v       <= 1'b0;
         exp_rvalid <= 1'b0;
         run_m      <= 1'b0;
         alloc_m    <= 1'b0;
         base_m     <= '0;
         out_count  <= 0;
      end else begin
         p1_v     <= host_v_i;
         p1_we    <= host_we_i;
         p1_addr  <= bp_addr_t'(host_addr_i);
         p1_wdata <= host_wdata_i;
         p2_v     <= p1_v;
         p2_low   <= (p1_addr < win_split_lp);
         p2_we    <= p1_we;
         p2_wdata <= p1_wdata;
         p2_oob   <= (p1_addr >= dram_limit_lp);
         // the base is the one present when the second stage registers
         p2_dram_addr  <= p1_addr + base_m;
         p2_local_addr <= p1_addr - win_split_lp;
         if (csr_we_i && csr_idx_i == csr_run_lp) run_m <= csr_wdata_i[0];
         if (csr_we_i && csr_idx_i == csr_alloc_lp) alloc_m <= csr_wdata_i[0];
         if (csr_we_i && csr_idx_i == csr_base_lp) base_m <= csr_wdata_i;
         exp_rvalid <= csr_re_i;
         if (csr_re_i) exp_rdata <= expected_read(csr_idx_i);
         if (local_v_o || dram_v_o) out_count <= out_count + 1;
      end
   end

   // region bits are set one cycle after stage one, cleared while the core is in reset
   always_ff @(posedge clk_i) begin
      if (reset_i || !run_m) begin
         map_m <= '0;
      end else if (p1_v && (p1_addr < win_split_lp)) begin
         map_m[p1_addr[29:23]] <= 1'b1;
      end
   end

   // outputs are compared on the falling edge, well away from the drive time
   a_dram_v: assert property (@(negedge clk_i) disable iff (reset_i)
      (p2_v && p2_low) |-> dram_v_o) else report_mismatch("dram_v_o", 1, word_t'(dram_v_o));
   a_dram_addr: assert property (@(negedge clk_i) disable iff (reset_i)
      (p2_v && p2_low) |-> (dram_addr_o == p2_dram_addr))
      else report_mismatch("dram_addr_o", p2_dram_addr, dram_addr_o);
   a_dram_we: assert property (@(negedge clk_i) disable iff (reset_i)
      (p2_v && p2_low) |-> (dram_we_o == p2_we))
      else report_mismatch("dram_we_o", word_t'(p2_we), word_t'(dram_we_o));
   a_dram_wdata: assert property (@(negedge clk_i) disable iff (reset_i)
      (p2_v && p2_low) |-> (dram_wdata_o == p2_wdata))
      else report_mismatch("dram_wdata_o", p2_wdata, dram_wdata_o);
   a_dram_oob: assert property (@(negedge clk_i) disable iff (reset_i)
      (p2_v && p2_low) |-> (dram_oob_o == p2_oob))
      else report_mismatch("dram_oob_o", word_t'(p2_oob), word_t'(dram_oob_o));
   a_local_v: assert property (@(negedge clk_i) disable iff (reset_i)
      (p2_v && !p2_low) |-> local_v_o) else report_mismatch("local_v_o", 1, word_t'(local_v_o));
   a_local_addr: assert property (@(negedge clk_i) disable iff (reset_i)
      (p2_v && !p2_low) |-> (local_addr_o == p2_local_addr))
      else report_mismatch("local_addr_o", p2_local_addr, local_addr_o);
   a_local_we: assert property (@(negedge clk_i) disable iff (reset_i)
      (p2_v && !p2_low) |-> (local_we_o == p2_we))
      else report_mismatch("local_we_o", word_t'(p2_we), word_t'(local_we_o));
   a_local_wdata: assert property (@(negedge clk_i) disable iff (reset_i)
      (p2_v && !p2_low) |-> (local_wdata_o == p2_wdata))
      else report_mismatch("local_wdata_o", p2_wdata, local_wdata_o);
   a_no_local_for_dram: assert property (@(negedge clk_i) disable iff (reset_i)
      (!p2_v || p2_low) |-> !local_v_o) else report_mismatch("local_v_o", 0, word_t'(local_v_o));
   a_no_dram_for_local: assert property (@(negedge clk_i) disable iff (reset_i)
      (!p2_v || !p2_low) |-> !dram_v_o) else report_mismatch("dram_v_o", 0, word_t'(dram_v_o));
   a_rvalid: assert property (@(negedge clk_i) disable iff (reset_i)
      csr_rvalid_o == exp_rvalid)
      else report_mismatch("csr_rvalid_o", word_t'(exp_rvalid), word_t'(csr_rvalid_o));
   a_rdata: assert property (@(negedge clk_i) disable iff (reset_i)
      exp_rvalid |-> (csr_rdata_o == exp_rdata))
      else report_mismatch("csr_rdata_o", exp_rdata, csr_rdata_o);
   a_core_reset: assert property (@(negedge clk_i) disable iff (reset_i)
      core_reset_o == !run_m)
      else report_mismatch("core_reset_o", word_t'(!run_m), word_t'(core_reset_o));

   task automatic next_drive_slot();
      @(posedge clk_i);
      #2;
   endtask

   task automatic write_csr(input csr_idx_t idx, input word_t data);
      next_drive_slot();
      csr_we_i    = 1'b1;
      csr_idx_i   = idx;
      csr_wdata_i = data;
      next_drive_slot();
      csr_we_i = 1'b0;
   endtask

   task automatic read_csr(input csr_idx_t idx);
      int cycles;
      next_drive_slot();
      csr_re_i  = 1'b1;
      csr_idx_i = idx;
      next_drive_slot();
      csr_re_i = 1'b0;
      cycles = 0;
      @(negedge clk_i);
      while (!csr_rvalid_o) begin
         if (cycles >= wait_limit_lp) report_timeout("CSR read returned no csr_rvalid_o");
         @(negedge clk_i);
         cycles++;
      end
   endtask

   task automatic read_profiler();
      for (int i = 4; i < 8; i++) begin
         read_csr(csr_idx_t'(i));
      end
   endtask

   // leaves host_v_i high so that consecutive calls issue back-to-back accesses
   task automatic host_access(input logic we, input gp1_addr_t addr, input word_t data);
      next_drive_slot();
      host_v_i     = 1'b1;
      host_we_i    = we;
      host_addr_i  = addr;
      host_wdata_i = data;
      issued_count++;
   endtask

   task automatic end_host_traffic();
      next_drive_slot();
      host_v_i = 1'b0;
   endtask

   task automatic wait_drained();
      int cycles;
      cycles = 0;
      while (out_count != issued_count) begin
         if (cycles >= wait_limit_lp) report_timeout("host accesses did not all reach a port");
         @(negedge clk_i);
         cycles++;
      end
   endtask

   task automatic wait_core_reset(input logic level);
      int cycles;
      cycles = 0;
      @(negedge clk_i);
      while (core_reset_o != level) begin
         if (cycles >= wait_limit_lp) report_timeout("core_reset_o did not follow the run bit");
         @(negedge clk_i);
         cycles++;
      end
   endtask

   initial begin
      void'($urandom(32'h1fb8_7806));
      reset_i      = 1'b1;
      host_v_i     = 1'b0;
      host_we_i    = 1'b0;
      host_addr_i  = '0;
      host_wdata_i = '0;
      csr_we_i     = 1'b0;
      csr_re_i     = 1'b0;
      csr_idx_i    = '0;
      csr_wdata_i  = '0;
      issued_count = 0;
      repeat (10) @(posedge clk_i);
      #2;
      reset_i = 1'b0;

      rand_base = $urandom();
      write_csr(csr_alloc_lp, 32'd1);
      write_csr(csr_base_lp, rand_base);
      write_csr(csr_run_lp, 32'd1);
      for (int i = 0; i < 3; i++) read_csr(csr_idx_t'(i));

      // single DRAM accesses to known regions, one inside and one past 256 MB
      host_access(1'b1, 30'h0000_1040, $urandom());
      end_host_traffic();
      wait_drained();
      host_access(1'b0, 30'h1c80_0010, $urandom());
      end_host_traffic();
      wait_drained();
      host_access(1'b1, 30'h0a00_0000 | gp1_addr_t'($urandom() & 32'h007f_fffc), $urandom());
      end_host_traffic();
      wait_drained();

      // a single local access, then a back-to-back mix of both windows
      host_access(1'b1, 30'h2000_0000, $urandom());
      end_host_traffic();
      wait_drained();
      for (int i = 0; i < 16; i++) begin
         host_access(1'($urandom()), gp1_addr_t'($urandom()), $urandom());
      end
      end_host_traffic();
      wait_drained();
      read_profiler();

      // dropping the run bit clears the bitmap, which stays clear after restart
      write_csr(csr_run_lp, 32'd0);
      wait_core_reset(1'b1);
      read_profiler();
      // run and alloc now differ, so their read-back slots can be told apart
      for (int i = 0; i < 3; i++) read_csr(csr_idx_t'(i));
      write_csr(csr_run_lp, 32'd1);
      wait_core_reset(1'b0);
      read_profiler();
      host_access(1'b0, 30'h1580_0000 | gp1_addr_t'($urandom() & 32'h007f_ffff), $urandom());
      end_host_traffic();
      wait_drained();
      read_profiler();
      for (int i = 0; i < 3; i++) read_csr(csr_idx_t'(i));

      $display("Everything OK");
      $finish;
   end

endmodule

// ==== project.f ====
design/bridge_addr_pkg.sv
design/bridge_csr_pkg.sv
design/gp1_window_xlate.sv
design/dram_rebase.sv
design/mem_region_profiler.sv
design/host_csr_block.sv
design/zynq_bridge_top.sv
dv/zynq_bridge_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

log_file=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
   --timescale 1ns/1ps \
   --top-module zynq_bridge_tb \
   -f project.f \
   -o sim_zynq_bridge

# the log decides the result, so a failing run must not stop the script here
./obj_dir/sim_zynq_bridge 2>&1 | tee "${log_file}"

if grep -q "^Everything OK$" "${log_file}"; then
   echo "simulation passed"
else
   echo "simulation failed, see ${log_file}"
   exit 1
fi
